/* common/pe_array_pkg.sv */
package pe_array_pkg;

    ////////////////////
    // array geometry
    ////////////////////

    localparam int NUM_ROWS = 3;
    localparam int NUM_COLS = 4;

    // datapath widths
    localparam int DATA_W   = 16;
    localparam int PSUM_W   = 32;
    localparam int ROW_ID_W = 2;
    localparam int COL_ID_W = 3;

    // operand pairs per compute
    localparam int MAC_LEN  = 4;

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [PSUM_W-1:0]   psum_t;
    typedef logic [ROW_ID_W-1:0] row_id_t;
    typedef logic [COL_ID_W-1:0] col_id_t;

    typedef enum logic [1:0] {
        OP_NOP     = 2'd0,
        OP_COMPUTE = 2'd1
    } opcode_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_MAC  = 2'd1,
        ST_ACC  = 2'd2,
        ST_SEND = 2'd3
    } pe_state_t;

endpackage

/* hw/gin/gin_bus.sv */
`timescale 1ns/1ps

module gin_bus
    import pe_array_pkg::*;
#(
    parameter int SLV_NUM   = NUM_ROWS,
    parameter int ID_W      = ROW_ID_W,
    parameter int PAYLOAD_W = DATA_W
) (
    input  logic                          i_clk,
    input  logic                          i_rst,

    // id table load
    input  logic [SLV_NUM-1:0][ID_W-1:0]  i_id,
    input  logic                          i_id_valid,

    // tagged packet from master
    input  logic [ID_W-1:0]               i_tag,
    input  logic [PAYLOAD_W-1:0]          i_payload,
    input  logic                          i_valid,
    output logic                          o_ready,

    // multicast to slaves
    output logic [PAYLOAD_W-1:0]          o_payload,
    output logic [SLV_NUM-1:0]            o_valid,
    input  logic [SLV_NUM-1:0]            i_slv_ready
);

    logic [SLV_NUM-1:0][ID_W-1:0] id_table;
    logic [SLV_NUM-1:0]           match;
    logic                         all_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            id_table <= '0;
        end else if (i_id_valid) begin
            id_table <= i_id;
        end
    end

    always_comb begin
        for (int s = 0; s < SLV_NUM; s++) begin
            match[s] = (id_table[s] == i_tag);
        end
    end

    // slaves that do not match never hold the bus back
    assign all_ready = &(i_slv_ready | ~match);

    // valid only when every target can take it, so the multicast is atomic
    assign o_valid   = match & {SLV_NUM{i_valid & all_ready}};
    assign o_payload = i_payload;
    assign o_ready   = all_ready;

endmodule

/* hw/gin/gin_network.sv */
`timescale 1ns/1ps

module gin_network
    import pe_array_pkg::*;
(
    input  logic                               i_clk,
    input  logic                               i_rst,

    // id tables
    input  row_id_t [NUM_ROWS-1:0]             i_row_id,
    input  logic                               i_row_id_valid,
    input  col_id_t [NUM_COLS-1:0]             i_col_id,
    input  logic [NUM_ROWS-1:0]                i_col_id_valid,

    // packet in
    input  row_id_t                            i_row_tag,
    input  col_id_t                            i_col_tag,
    input  data_t                              i_data,
    input  logic                               i_valid,
    output logic                               o_ready,

    // to the pe grid
    output data_t [NUM_ROWS-1:0]               o_pe_data,
    output logic [NUM_ROWS-1:0][NUM_COLS-1:0]  o_pe_valid,
    input  logic [NUM_ROWS-1:0][NUM_COLS-1:0]  i_pe_ready
);

    // column tag rides along with the data on the row bus
    logic [COL_ID_W+DATA_W-1:0] row_payload;
    logic [NUM_ROWS-1:0]        row_valid;
    logic [NUM_ROWS-1:0]        col_ready;

    gin_bus #(
        .SLV_NUM   (NUM_ROWS),
        .ID_W      (ROW_ID_W),
        .PAYLOAD_W (COL_ID_W + DATA_W)
    ) u_row_bus (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_id        (i_row_id),
        .i_id_valid  (i_row_id_valid),
        .i_tag       (i_row_tag),
        .i_payload   ({i_col_tag, i_data}),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .o_payload   (row_payload),
        .o_valid     (row_valid),
        .i_slv_ready (col_ready)
    );

    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_col_bus
        gin_bus #(
            .SLV_NUM   (NUM_COLS),
            .ID_W      (COL_ID_W),
            .PAYLOAD_W (DATA_W)
        ) u_col_bus (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_id        (i_col_id),
            .i_id_valid  (i_col_id_valid[r]),
            .i_tag       (row_payload[DATA_W +: COL_ID_W]),
            .i_payload   (row_payload[DATA_W-1:0]),
            .i_valid     (row_valid[r]),
            .o_ready     (col_ready[r]),
            .o_payload   (o_pe_data[r]),
            .o_valid     (o_pe_valid[r]),
            .i_slv_ready (i_pe_ready[r])
        );
    end

endmodule

/* hw/pe/pe.sv */
`timescale 1ns/1ps

module pe
    import pe_array_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,

    input  opcode_t i_opcode,
    input  logic    i_opcode_valid,
    output logic    o_idle,
    input  logic    i_acc_en,

    input  data_t   i_ifmap,
    input  logic    i_ifmap_valid,
    output logic    o_ifmap_ready,
    input  data_t   i_wght,
    input  logic    i_wght_valid,
    output logic    o_wght_ready,

    // psum from the pe below
    input  psum_t   i_psum_in,
    input  logic    i_psum_in_valid,
    output logic    o_psum_in_ready,

    output psum_t   o_psum_out,
    output logic    o_psum_out_valid,
    input  logic    i_psum_out_ready
);

    pe_state_t                    state;
    data_t                        ifmap_q;
    data_t                        wght_q;
    logic                         ifmap_full;
    logic                         wght_full;
    logic [$clog2(MAC_LEN)-1:0]   mac_cnt;
    psum_t                        acc;
    logic                         start;
    logic                         ifmap_take;
    logic                         wght_take;
    logic                         mac_fire;
    logic                         acc_fire;

    assign o_idle          = (state == ST_IDLE);
    assign o_ifmap_ready   = (state == ST_MAC) && !ifmap_full;
    assign o_wght_ready    = (state == ST_MAC) && !wght_full;
    assign o_psum_in_ready = (state == ST_ACC);

    assign start      = o_idle && i_opcode_valid && (i_opcode == OP_COMPUTE);
    assign ifmap_take = i_ifmap_valid && o_ifmap_ready;
    assign wght_take  = i_wght_valid && o_wght_ready;
    assign mac_fire   = (state == ST_MAC) && ifmap_full && wght_full;
    assign acc_fire   = i_psum_in_valid && o_psum_in_ready;

    ////////////////////
    // control fsm
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= ST_IDLE;
            ifmap_full <= 1'b0;
            wght_full  <= 1'b0;
            mac_cnt    <= '0;
        end else begin
            case (state)
                // OP_NOP is taken here and has no effect
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_MAC;
                        mac_cnt <= '0;
                    end
                end
                ST_MAC: begin
                    if (mac_fire) begin
                        ifmap_full <= 1'b0;
                        wght_full  <= 1'b0;
                        mac_cnt    <= mac_cnt + 1'b1;
                        if (int'(mac_cnt) == MAC_LEN - 1) begin
                            state <= i_acc_en ? ST_ACC : ST_SEND;
                        end
                    end else begin
                        if (ifmap_take) begin
                            ifmap_full <= 1'b1;
                        end
                        if (wght_take) begin
                            wght_full <= 1'b1;
                        end
                    end
                end
                ST_ACC: begin
                    if (acc_fire) begin
                        state <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (i_psum_out_ready) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // operands and accumulator
    always_ff @(posedge i_clk) begin
        if (ifmap_take) begin
            ifmap_q <= i_ifmap;
        end
        if (wght_take) begin
            wght_q <= i_wght;
        end
        if (start) begin
            acc <= '0;
        end else if (mac_fire) begin
            acc <= acc + (psum_t'(ifmap_q) * psum_t'(wght_q));
        end else if (acc_fire) begin
            acc <= acc + i_psum_in;
        end
    end

    assign o_psum_out       = acc;
    assign o_psum_out_valid = (state == ST_SEND);

endmodule

/* hw/pe_array_top.sv */
`timescale 1ns/1ps

module pe_array_top
    import pe_array_pkg::*;
(
    input  logic                         i_clk,
    input  logic                         i_rst,

    input  opcode_t                      i_inst_data,
    input  logic                         i_inst_valid,
    output logic                         o_inst_ready,

    input  row_id_t [NUM_ROWS-1:0]       i_ifmap_row_id,
    input  logic                         i_ifmap_row_id_valid,
    input  col_id_t [NUM_COLS-1:0]       i_ifmap_col_id,
    input  logic [NUM_ROWS-1:0]          i_ifmap_col_id_valid,
    input  row_id_t [NUM_ROWS-1:0]       i_wght_row_id,
    input  logic                         i_wght_row_id_valid,
    input  col_id_t [NUM_COLS-1:0]       i_wght_col_id,
    input  logic [NUM_ROWS-1:0]          i_wght_col_id_valid,

    input  row_id_t                      i_ifmap_row_tag,
    input  col_id_t                      i_ifmap_col_tag,
    input  data_t                        i_ifmap_data,
    input  logic                         i_ifmap_valid,
    output logic                         o_ifmap_ready,
    input  row_id_t                      i_wght_row_tag,
    input  col_id_t                      i_wght_col_tag,
    input  data_t                        i_wght_data,
    input  logic                         i_wght_valid,
    output logic                         o_wght_ready,

    input  logic [NUM_ROWS*NUM_COLS-1:0] i_psum_in_sel,
    input  logic [NUM_ROWS*NUM_COLS-1:0] i_psum_out_sel,

    output psum_t                        o_psum_out_data,
    output logic                         o_psum_out_valid,
    input  logic                         i_psum_out_ready
);

    data_t [NUM_ROWS-1:0]              ifmap_pe_data;
    data_t [NUM_ROWS-1:0]              wght_pe_data;
    logic [NUM_ROWS-1:0][NUM_COLS-1:0] ifmap_pe_valid;
    logic [NUM_ROWS-1:0][NUM_COLS-1:0] ifmap_pe_ready;
    logic [NUM_ROWS-1:0][NUM_COLS-1:0] wght_pe_valid;
    logic [NUM_ROWS-1:0][NUM_COLS-1:0] wght_pe_ready;
    logic [NUM_ROWS*NUM_COLS-1:0]      pe_idle;

    // local psum chain
    psum_t psum_data     [NUM_ROWS][NUM_COLS];
    logic  psum_valid    [NUM_ROWS][NUM_COLS];
    logic  psum_ready    [NUM_ROWS][NUM_COLS];
    psum_t psum_in       [NUM_ROWS][NUM_COLS];
    logic  psum_in_valid [NUM_ROWS][NUM_COLS];
    logic  psum_in_ready [NUM_ROWS][NUM_COLS];

    gin_network u_ifmap_gin (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_row_id       (i_ifmap_row_id),
        .i_row_id_valid (i_ifmap_row_id_valid),
        .i_col_id       (i_ifmap_col_id),
        .i_col_id_valid (i_ifmap_col_id_valid),
        .i_row_tag      (i_ifmap_row_tag),
        .i_col_tag      (i_ifmap_col_tag),
        .i_data         (i_ifmap_data),
        .i_valid        (i_ifmap_valid),
        .o_ready        (o_ifmap_ready),
        .o_pe_data      (ifmap_pe_data),
        .o_pe_valid     (ifmap_pe_valid),
        .i_pe_ready     (ifmap_pe_ready)
    );

    gin_network u_wght_gin (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_row_id       (i_wght_row_id),
        .i_row_id_valid (i_wght_row_id_valid),
        .i_col_id       (i_wght_col_id),
        .i_col_id_valid (i_wght_col_id_valid),
        .i_row_tag      (i_wght_row_tag),
        .i_col_tag      (i_wght_col_tag),
        .i_data         (i_wght_data),
        .i_valid        (i_wght_valid),
        .o_ready        (o_wght_ready),
        .o_pe_data      (wght_pe_data),
        .o_pe_valid     (wght_pe_valid),
        .i_pe_ready     (wght_pe_ready)
    );

    ////////////////////
    // pe grid
    ////////////////////

    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row
        for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
            localparam int IDX = r * NUM_COLS + c;

            // bottom row has nothing below it
            if (r == NUM_ROWS - 1) begin : g_bottom
                assign psum_in[r][c]       = '0;
                assign psum_in_valid[r][c] = 1'b0;
            end else begin : g_link
                assign psum_in[r][c]       = psum_data[r+1][c];
                assign psum_in_valid[r][c] = psum_valid[r+1][c];
            end

            // taken by the output port or by the pe above
            if (r == 0) begin : g_top
                assign psum_ready[r][c] = i_psum_out_sel[IDX] & i_psum_out_ready;
            end else begin : g_inner
                assign psum_ready[r][c] = (i_psum_out_sel[IDX] & i_psum_out_ready)
                    | (i_psum_in_sel[IDX-NUM_COLS] & psum_in_ready[r-1][c]);
            end

            pe u_pe (
                .i_clk            (i_clk),
                .i_rst            (i_rst),
                .i_opcode         (i_inst_data),
                .i_opcode_valid   (i_inst_valid & o_inst_ready),
                .o_idle           (pe_idle[IDX]),
                .i_acc_en         (i_psum_in_sel[IDX]),
                .i_ifmap          (ifmap_pe_data[r]),
                .i_ifmap_valid    (ifmap_pe_valid[r][c]),
                .o_ifmap_ready    (ifmap_pe_ready[r][c]),
                .i_wght           (wght_pe_data[r]),
                .i_wght_valid     (wght_pe_valid[r][c]),
                .o_wght_ready     (wght_pe_ready[r][c]),
                .i_psum_in        (psum_in[r][c]),
                .i_psum_in_valid  (psum_in_valid[r][c]),
                .o_psum_in_ready  (psum_in_ready[r][c]),
                .o_psum_out       (psum_data[r][c]),
                .o_psum_out_valid (psum_valid[r][c]),
                .i_psum_out_ready (psum_ready[r][c])
            );
        end
    end

    // one-hot output select, zero when nothing is picked
    always_comb begin
        o_psum_out_data  = '0;
        o_psum_out_valid = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (i_psum_out_sel[r*NUM_COLS+c]) begin
                    o_psum_out_data  = psum_data[r][c];
                    o_psum_out_valid = psum_valid[r][c];
                end
            end
        end
    end

    assign o_inst_ready = &pe_idle;

endmodule

/* verif/pe_array_sva.sv */
`timescale 1ns/1ps

module pe_array_sva
    import pe_array_pkg::*;
(
    input logic                         i_clk,
    input logic                         i_rst,
    input logic                         o_inst_ready,
    input psum_t                        o_psum_out_data,
    input logic                         o_psum_out_valid,
    input logic                         i_psum_out_ready,
    input logic [NUM_ROWS*NUM_COLS-1:0] i_psum_out_sel
);

    // stalled output stays put unless the select moved
    a_out_hold: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_psum_out_valid && !i_psum_out_ready |=>
            !$stable(i_psum_out_sel) || (o_psum_out_valid && $stable(o_psum_out_data))
    ) else $error("psum output changed while stalled");

    a_reset_idle: assert property (
        @(posedge i_clk) $fell(i_rst) |-> o_inst_ready && !o_psum_out_valid
    ) else $error("array not idle after reset");

    a_sel_onehot: assert property (
        @(posedge i_clk) disable iff (i_rst) $onehot0(i_psum_out_sel)
    ) else $error("more than one output select bit set");

endmodule

bind pe_array_top pe_array_sva u_sva (.*);

/* verif/pe_array_tb.sv */
`timescale 1ns/1ps

module pe_array_tb
    import pe_array_pkg::*;
();

    localparam int TIMEOUT   = 1000;
    localparam int NUM_PE    = NUM_ROWS * NUM_COLS;
    localparam int MAX_LINES = 16;

    logic                        i_clk;
    logic                        i_rst;
    opcode_t                     i_inst_data;
    logic                        i_inst_valid;
    logic                        o_inst_ready;
    row_id_t [NUM_ROWS-1:0]      i_ifmap_row_id;
    logic                        i_ifmap_row_id_valid;
    col_id_t [NUM_COLS-1:0]      i_ifmap_col_id;
    logic [NUM_ROWS-1:0]         i_ifmap_col_id_valid;
    row_id_t [NUM_ROWS-1:0]      i_wght_row_id;
    logic                        i_wght_row_id_valid;
    col_id_t [NUM_COLS-1:0]      i_wght_col_id;
    logic [NUM_ROWS-1:0]         i_wght_col_id_valid;
    row_id_t                     i_ifmap_row_tag;
    col_id_t                     i_ifmap_col_tag;
    data_t                       i_ifmap_data;
    logic                        i_ifmap_valid;
    logic                        o_ifmap_ready;
    row_id_t                     i_wght_row_tag;
    col_id_t                     i_wght_col_tag;
    data_t                       i_wght_data;
    logic                        i_wght_valid;
    logic                        o_wght_ready;
    logic [NUM_PE-1:0]           i_psum_in_sel;
    logic [NUM_PE-1:0]           i_psum_out_sel;
    psum_t                       o_psum_out_data;
    logic                        o_psum_out_valid;
    logic                        i_psum_out_ready;

    logic [31:0] lfsr;

    // queued packet lines, one per stream, each with MAC_LEN values
    row_id_t pkt_rt  [2][MAX_LINES];
    col_id_t pkt_ct  [2][MAX_LINES];
    data_t   pkt_d   [2][MAX_LINES][MAC_LEN];
    int      pkt_cnt [2];

    pe_array_top dut (.*);

    always #10 i_clk = ~i_clk;

    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_psum(input string name, input psum_t exp, input psum_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            $display("Checks failed");
            $fatal(1, "psum mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("Checks failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("Checks failed");
        $fatal(1, "timeout");
    endtask

    ////////////////////
    // drivers
    ////////////////////

    task automatic load_row_ids(input int s, input int a, input int b, input int c);
        row_id_t [NUM_ROWS-1:0] ids;
        ids = {row_id_t'(c), row_id_t'(b), row_id_t'(a)};
        if (s == 0) begin
            i_ifmap_row_id       <= ids;
            i_ifmap_row_id_valid <= 1'b1;
        end else begin
            i_wght_row_id       <= ids;
            i_wght_row_id_valid <= 1'b1;
        end
        @(posedge i_clk);
        i_ifmap_row_id_valid <= 1'b0;
        i_wght_row_id_valid  <= 1'b0;
    endtask

    task automatic load_col_ids(input int s, input int mask, input int a, input int b,
                                input int c, input int d);
        col_id_t [NUM_COLS-1:0] ids;
        ids = {col_id_t'(d), col_id_t'(c), col_id_t'(b), col_id_t'(a)};
        if (s == 0) begin
            i_ifmap_col_id       <= ids;
            i_ifmap_col_id_valid <= mask[NUM_ROWS-1:0];
        end else begin
            i_wght_col_id       <= ids;
            i_wght_col_id_valid <= mask[NUM_ROWS-1:0];
        end
        @(posedge i_clk);
        i_ifmap_col_id_valid <= '0;
        i_wght_col_id_valid  <= '0;
    endtask

    task automatic send_packet(input int s, input row_id_t rt, input col_id_t ct,
                               input data_t d);
        int   n;
        logic rdy;
        n = 0;
        if (s == 0) begin
            i_ifmap_row_tag <= rt;
            i_ifmap_col_tag <= ct;
            i_ifmap_data    <= d;
            i_ifmap_valid   <= 1'b1;
        end else begin
            i_wght_row_tag <= rt;
            i_wght_col_tag <= ct;
            i_wght_data    <= d;
            i_wght_valid   <= 1'b1;
        end
        do begin
            @(posedge i_clk);
            n++;
            rdy = (s == 0) ? o_ifmap_ready : o_wght_ready;
            if (!rdy && n >= TIMEOUT) begin
                stop_on_timeout("packet ready");
            end
        end while (!rdy);
    endtask

    // one value per line and round, so no pe waits on a later round
    task automatic feed_stream(input int s);
        for (int k = 0; k < MAC_LEN; k++) begin
            for (int i = 0; i < pkt_cnt[s]; i++) begin
                send_packet(s, pkt_rt[s][i], pkt_ct[s][i], pkt_d[s][i][k]);
            end
        end
        if (s == 0) begin
            i_ifmap_valid <= 1'b0;
        end else begin
            i_wght_valid <= 1'b0;
        end
        pkt_cnt[s] = 0;
    endtask

    task automatic issue_inst(input opcode_t op);
        int n;
        n = 0;
        i_inst_data  <= op;
        i_inst_valid <= 1'b1;
        do begin
            @(posedge i_clk);
            n++;
            if (!o_inst_ready && n >= TIMEOUT) begin
                stop_on_timeout("instruction ready");
            end
        end while (!o_inst_ready);
        i_inst_valid <= 1'b0;
        // busy right after a compute, still idle after a nop
        @(posedge i_clk);
        check_flag("inst ready after issue", op != OP_COMPUTE, o_inst_ready);
    endtask

    task automatic read_result(input string name, input logic [NUM_PE-1:0] sel,
                               input psum_t exp);
        int    n;
        logic  held;
        logic  done;
        psum_t held_data;
        n    = 0;
        held = 1'b0;
        done = 1'b0;
        i_psum_out_sel   <= sel;
        i_psum_out_ready <= 1'b0;
        while (!done) begin
            @(posedge i_clk);
            n++;
            if (held) begin
                check_flag({name, " valid held"}, 1'b1, o_psum_out_valid);
                check_psum({name, " data held"}, held_data, o_psum_out_data);
            end
            if (o_psum_out_valid && i_psum_out_ready) begin
                check_psum(name, exp, o_psum_out_data);
                done = 1'b1;
            end else begin
                if (n >= TIMEOUT) begin
                    stop_on_timeout("psum output");
                end
                held      = o_psum_out_valid;
                held_data = o_psum_out_data;
                i_psum_out_ready <= next_bit();
            end
        end
        i_psum_out_ready <= 1'b0;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int    fd;
        string line;
        string name;
        byte   cmd;
        int    v [8];

        i_clk                = 1'b0;
        i_rst                = 1'b1;
        i_inst_data          = OP_NOP;
        i_inst_valid         = 1'b0;
        i_ifmap_row_id       = '0;
        i_ifmap_row_id_valid = 1'b0;
        i_ifmap_col_id       = '0;
        i_ifmap_col_id_valid = '0;
        i_wght_row_id        = '0;
        i_wght_row_id_valid  = 1'b0;
        i_wght_col_id        = '0;
        i_wght_col_id_valid  = '0;
        i_ifmap_row_tag      = '0;
        i_ifmap_col_tag      = '0;
        i_ifmap_data         = '0;
        i_ifmap_valid        = 1'b0;
        i_wght_row_tag       = '0;
        i_wght_col_tag       = '0;
        i_wght_data          = '0;
        i_wght_valid         = 1'b0;
        i_psum_in_sel        = '0;
        i_psum_out_sel       = '0;
        i_psum_out_ready     = 1'b0;
        lfsr                 = 32'h81373b81;
        pkt_cnt[0]           = 0;
        pkt_cnt[1]           = 0;

        fd = $fopen("verif/pe_array_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            $display("Checks failed");
            $fatal(1, "no stimulus");
        end

        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);
        check_flag("inst ready after reset", 1'b1, o_inst_ready);
        check_flag("psum valid after reset", 1'b0, o_psum_out_valid);
        // zero tags hit the zero tables while every pe is idle
        check_flag("ifmap ready after reset", 1'b0, o_ifmap_ready);
        check_flag("wght ready after reset", 1'b0, o_wght_ready);

        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            cmd = line[0];
            case (cmd)
                "R": begin
                    void'($sscanf(line, "%c %d %d %d %d", cmd, v[0], v[1], v[2], v[3]));
                    load_row_ids(v[0], v[1], v[2], v[3]);
                end
                "C": begin
                    void'($sscanf(line, "%c %d %d %d %d %d %d", cmd, v[0], v[1], v[2],
                                  v[3], v[4], v[5]));
                    load_col_ids(v[0], v[1], v[2], v[3], v[4], v[5]);
                end
                "P": begin
                    void'($sscanf(line, "%c %d %d %d %d %d %d %d", cmd, v[0], v[1], v[2],
                                  v[3], v[4], v[5], v[6]));
                    pkt_rt[v[0]][pkt_cnt[v[0]]] = row_id_t'(v[1]);
                    pkt_ct[v[0]][pkt_cnt[v[0]]] = col_id_t'(v[2]);
                    for (int k = 0; k < MAC_LEN; k++) begin
                        pkt_d[v[0]][pkt_cnt[v[0]]][k] = data_t'(v[3+k]);
                    end
                    pkt_cnt[v[0]]++;
                end
                "S": begin
                    void'($sscanf(line, "%c %h", cmd, v[0]));
                    i_psum_in_sel <= v[0][NUM_PE-1:0];
                end
                "I": begin
                    void'($sscanf(line, "%c %d", cmd, v[0]));
                    issue_inst(opcode_t'(v[0]));
                end
                "F": begin
                    fork
                        feed_stream(0);
                        feed_stream(1);
                    join
                end
                "X": begin
                    void'($sscanf(line, "%c %s %h %d", cmd, name, v[0], v[1]));
                    read_result(name, v[0][NUM_PE-1:0], psum_t'(v[1]));
                end
                "Q": begin
                    void'($sscanf(line, "%c %d", cmd, v[0]));
                    @(posedge i_clk);
                    check_flag("inst ready", v[0][0], o_inst_ready);
                end
                default: begin
                    $display("unknown command in the stimulus file: %s", line);
                    $display("Checks failed");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end

        $fclose(fd);
        $display("All checks passed");
        $finish;
    end

endmodule

/* verif/pe_array_stimulus.txt */
# R stream id0 id1 id2 | C stream row_mask id0 id1 id2 id3 | P stream row_tag col_tag d0 d1 d2 d3
# S in_sel(hex) | I opcode | F feed packets | X name out_sel(hex) expected | Q inst_ready
R 0 0 1 2
C 0 7 2 2 2 2
R 1 1 1 1
C 1 7 0 1 2 3
I 0
P 0 0 2 1 2 3 4
P 0 1 2 5 6 7 8
P 0 2 2 9 10 11 12
P 0 3 2 999 999 999 999
P 1 1 0 1 1 1 1
P 1 1 1 1 2 3 4
P 1 1 2 2 0 2 0
P 1 1 3 100 200 300 400
P 1 0 0 55 55 55 55
S 033
I 1
F
X chain_col0 001 78
X chain_col1 002 210
X pe_0_2 004 8
X pe_1_2 040 24
X pe_2_2 400 40
X pe_0_3 008 3000
X pe_1_3 080 7000
Q 0
X pe_2_3 800 11000
Q 1

/* sources.f */
common/pe_array_pkg.sv
hw/gin/gin_bus.sv
hw/gin/gin_network.sv
hw/pe/pe.sv
hw/pe_array_top.sv
verif/pe_array_sva.sv
verif/pe_array_tb.sv

/* Bender.yml */
package:
  name: pe_array

sources:
  - common/pe_array_pkg.sv
  - hw/gin/gin_bus.sv
  - hw/gin/gin_network.sv
  - hw/pe/pe.sv
  - hw/pe_array_top.sv
  - target: simulation
    files:
      - verif/pe_array_sva.sv
      - verif/pe_array_tb.sv
